// ==== compile.f ====
+incdir+hw
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/sync_fifo.sv
hw/uart_top.sv
bench/clk_gen.sv
bench/uart_top_checker.sv
bench/uart_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the UART subsystem testbench

VERILATOR ?= verilator
TOP       ?= uart_top_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) hw/uart_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/uart_top_tb.sv ====
// Directed testbench for the UART subsystem
// Serial driver and monitor, loopback mux, checking task, timeout and verdict

`timescale 1ns/1ns
`include "uart_params.svh"

module uart_top_tb;

    localparam int TICK_CMP  = 3;
    localparam int BIT_CYC   = `UART_OVERSAMPLE * (TICK_CMP + 1);   // 64 clocks per bit
    localparam int FRAME_CYC = 10 * BIT_CYC;
    localparam int LIMIT     = 90 * FRAME_CYC + 4000;

    logic                        clk;
    logic                        i_rst, i_tx_start, i_rd, i_wr, i_rx;
    logic                        drv_line, loop_sel;
    logic [`UART_NB_COUNTER-1:0] i_tick_cmp;
    uart_pkg::data_t             i_wdata, o_rdata;
    logic                        o_tx, o_tx_done, o_tx_empty, o_tx_full;
    logic                        o_rx_done, o_rx_empty, o_rx_full;
    logic                        rx_empty_q = 1'b1;
    int                          errors = 0;
    int                          rx_cnt = 0;
    int                          tx_cnt = 0;
    int                          cycles = 0;
    integer                      seed = 77803;

    clk_gen #(.PERIOD(40)) u_clk_gen (.o_clk(clk));

    assign i_rx = loop_sel ? o_tx : drv_line;   // Loopback or bench driver

    uart_top u_uart_top (.*);

    // Done pulse counters
    always @(negedge clk) begin
        if (o_rx_done === 1'b1) rx_cnt <= rx_cnt + 1;
        if (o_tx_done === 1'b1) tx_cnt <= tx_cnt + 1;
        // First byte into an empty receive FIFO shows up with the done pulse
        if ((rx_empty_q === 1'b1) && (o_rx_empty === 1'b0)) begin
            check_eq(o_rx_done, 1'b1, "o_rx_done when o_rx_empty falls");
        end
        rx_empty_q <= o_rx_empty;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", LIMIT);
            finish_run(errors + 1);
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
        end
    endtask

    task automatic finish_run(input int n);
        int total;
        total = n + u_uart_top.u_checker.fail_cnt;
        $display("Errors: %0d", total);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    function automatic uart_pkg::data_t rand_byte();
        return uart_pkg::data_t'($random(seed));
    endfunction

    task automatic write_byte(input uart_pkg::data_t b);
        @(posedge clk);
        i_wr    <= 1'b1;
        i_wdata <= b;
        @(posedge clk);
        i_wr    <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        i_tx_start <= 1'b1;
        @(posedge clk);
        i_tx_start <= 1'b0;
    endtask

    // Checks the head, then pops it
    task automatic read_byte(input uart_pkg::data_t exp, input string msg);
        logic have;
        @(negedge clk);
        have = !o_rx_empty;
        check_eq(have, 1'b1, {msg, ": receive FIFO not empty"});
        check_eq(o_rdata, exp, msg);
        @(posedge clk);
        i_rd <= have;
        @(posedge clk);
        i_rd <= 1'b0;
    endtask

    // Start, 8 data bits LSB first, stop; a bad stop bit is low for 3/4 of a bit
    task automatic send_frame(input uart_pkg::data_t b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            drv_line <= frame[i];
            repeat (((i == 9) && !stop) ? (3 * BIT_CYC / 4) - 1 : BIT_CYC - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;
    endtask

    // Finds the start edge on o_tx and samples each bit at its middle
    task automatic monitor_frame(output uart_pkg::data_t b);
        int n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((o_tx !== 1'b0) && (n < FRAME_CYC));
        if (n >= FRAME_CYC) begin
            errors++;
            $display("No start bit seen on the transmit line");
        end
        repeat (BIT_CYC / 2) @(negedge clk);
        check_eq(o_tx, 1'b0, "start bit");
        for (int i = 0; i < `UART_NB_DATA; i++) begin
            repeat (BIT_CYC) @(negedge clk);
            b[i] = o_tx;
        end
        repeat (BIT_CYC) @(negedge clk);
        check_eq(o_tx, 1'b1, "stop bit");
    endtask

    task automatic wait_done(input logic rx_side, input int target, input string what);
        int n = 0;
        while (((rx_side ? rx_cnt : tx_cnt) < target) && (n < 2 * FRAME_CYC)) begin
            @(negedge clk);
            n++;
        end
        if ((rx_side ? rx_cnt : tx_cnt) < target) begin
            errors++;
            $display("Timed out waiting for %s", what);
        end
    endtask

    task automatic verify_reset_values();
        @(negedge clk);
        check_eq(o_tx, 1'b1, "o_tx after reset");
        check_eq({o_tx_done, o_rx_done}, 2'b00, "done pulses after reset");
        check_eq({o_tx_empty, o_rx_empty}, 2'b11, "empty flags after reset");
        check_eq({o_tx_full, o_rx_full}, 2'b00, "full flags after reset");
    endtask

    task automatic transmit_one_byte();
        uart_pkg::data_t b, got;
        int              n;
        b = rand_byte();
        n = tx_cnt;
        write_byte(b);
        pulse_start();
        monitor_frame(got);
        check_eq(got, b, "transmitted byte");
        wait_done(1'b0, n + 1, "o_tx_done");
        @(negedge clk);
        check_eq(o_tx_empty, 1'b1, "o_tx_empty after frame");
    endtask

    task automatic receive_one_byte();
        uart_pkg::data_t b;
        int              n;
        b = rand_byte();
        n = rx_cnt;
        send_frame(b, 1'b1);
        wait_done(1'b1, n + 1, "o_rx_done");
        read_byte(b, "received byte");
        @(negedge clk);
        check_eq(o_rx_empty, 1'b1, "o_rx_empty after read");
    endtask

    task automatic reject_bad_stop();
        int n;
        n = rx_cnt;
        send_frame(rand_byte(), 1'b0);
        repeat (2 * FRAME_CYC) @(negedge clk);
        check_eq(rx_cnt, n, "o_rx_done count after bad stop bit");
        check_eq(o_rx_empty, 1'b1, "o_rx_empty after bad stop bit");
    endtask

    // Sends n bytes over the loopback, each after the previous o_tx_done
    task automatic loop_frames(input int count, input uart_pkg::data_t exp[$], input string tag);
        int n;
        n = rx_cnt;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            check_eq(o_rx_full, 1'b0, {tag, ": o_rx_full before frame"});
            pulse_start();
            wait_done(1'b0, tx_cnt + 1, "o_tx_done in loopback");
        end
        wait_done(1'b1, n + count, "loopback frames");
        @(negedge clk);
        check_eq(o_rx_full, (count >= 32), {tag, ": o_rx_full after frames"});
        for (int i = 0; i < count; i++) read_byte(exp[i], {tag, ": loopback byte"});
    endtask

    task automatic loopback_burst();
        uart_pkg::data_t exp_q[$];
        @(posedge clk);
        loop_sel <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            exp_q.push_back(rand_byte());
            write_byte(exp_q[i]);
        end
        loop_frames(20, exp_q, "burst");
    endtask

    task automatic fill_both_fifos();
        uart_pkg::data_t exp_q[$];
        for (int i = 0; i < 33; i++) begin
            exp_q.push_back(rand_byte());
            write_byte(exp_q[i]);
            @(negedge clk);
            check_eq(o_tx_full, (i >= 31), "o_tx_full after write");
        end
        loop_frames(32, exp_q, "limits");
        @(negedge clk);
        check_eq(o_tx_empty, 1'b1, "o_tx_empty, 33rd write dropped");
        check_eq(o_rx_empty, 1'b1, "o_rx_empty after drain");
    endtask

    initial begin
        i_rst      = 1'b1;
        i_tx_start = 1'b0;
        i_rd       = 1'b0;
        i_wr       = 1'b0;
        i_wdata    = '0;
        i_tick_cmp = `UART_NB_COUNTER'(TICK_CMP);
        drv_line   = 1'b1;        // Idle line
        loop_sel   = 1'b0;
        repeat (16) @(posedge clk);
        i_rst <= 1'b0;
        verify_reset_values();
        transmit_one_byte();
        receive_one_byte();
        reject_bad_stop();
        loopback_burst();
        fill_both_fifos();
        finish_run(errors);
    end

endmodule

// ==== bench/uart_top_checker.sv ====
// Protocol assertions for the UART subsystem
// Bound into uart_top, counts assertion failures

`timescale 1ns/1ns

module uart_top_checker (
    input logic                   clk,
    input logic                   i_rst,
    input logic                   i_rd,
    input logic                   i_rx_empty,
    input logic                   i_rx_full,
    input logic                   i_tx_empty,
    input logic                   i_tx_full,
    input logic                   i_tx,
    input logic                   i_tx_done,
    input logic                   i_rx_done,
    input uart_pkg::frame_state_e i_tx_state   // Transmitter FSM state
);

    int fail_cnt = 0;

    a_no_empty_read: assert property (@(posedge clk) disable iff (i_rst) !(i_rd && i_rx_empty))
        else begin
            $error("Receive FIFO read while empty");
            fail_cnt++;
        end
    a_tx_done_pulse: assert property (@(posedge clk) disable iff (i_rst) i_tx_done |=> !i_tx_done)
        else begin
            $error("o_tx_done longer than one cycle");
            fail_cnt++;
        end
    a_rx_done_pulse: assert property (@(posedge clk) disable iff (i_rst) i_rx_done |=> !i_rx_done)
        else begin
            $error("o_rx_done longer than one cycle");
            fail_cnt++;
        end
    a_idle_line_high: assert property (@(posedge clk) disable iff (i_rst)
        (i_tx_state == uart_pkg::IDLE) |-> i_tx)
        else begin
            $error("Serial line low while transmitter idle");
            fail_cnt++;
        end
    a_rx_flags: assert property (@(posedge clk) disable iff (i_rst) !(i_rx_empty && i_rx_full))
        else begin
            $error("Receive FIFO empty and full together");
            fail_cnt++;
        end
    a_tx_flags: assert property (@(posedge clk) disable iff (i_rst) !(i_tx_empty && i_tx_full))
        else begin
            $error("Transmit FIFO empty and full together");
            fail_cnt++;
        end

endmodule

bind uart_top uart_top_checker u_checker (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_rd       (i_rd),
    .i_rx_empty (o_rx_empty),
    .i_rx_full  (o_rx_full),
    .i_tx_empty (o_tx_empty),
    .i_tx_full  (o_tx_full),
    .i_tx       (o_tx),
    .i_tx_done  (o_tx_done),
    .i_rx_done  (o_rx_done),
    .i_tx_state (u_uart_tx.state)
);

// ==== bench/clk_gen.sv ====
// Testbench clock source
// Free-running clock with a programmable period

`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD = 40    // ns
) (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== hw/uart_top.sv ====
// UART subsystem top level
// Baud tick generator, receiver and transmitter with their FIFOs,
// and the registered receive-done pulse

`timescale 1ns/1ns
`include "uart_params.svh"

module uart_top (
    // Outputs
    output logic                        o_tx,         // Serial line out
    output logic                        o_tx_done,    // Frame sent
    output logic                        o_tx_empty,   // Transmit FIFO empty
    output logic                        o_tx_full,    // Transmit FIFO full
    output uart_pkg::data_t             o_rdata,      // Receive FIFO head
    output logic                        o_rx_done,    // Frame received, one cycle late
    output logic                        o_rx_empty,   // Receive FIFO empty
    output logic                        o_rx_full,    // Receive FIFO full

    // Inputs
    input  logic                        i_rx,         // Serial line in
    input  logic                        i_tx_start,   // Start one frame
    input  logic                        i_rd,         // Pop receive FIFO
    input  logic                        i_wr,         // Push transmit FIFO
    input  uart_pkg::data_t             i_wdata,
    input  logic [`UART_NB_COUNTER-1:0] i_tick_cmp,   // Baud tick period minus one
    input  logic                        i_rst,
    input  logic                        clk
);

    logic            tick;
    uart_pkg::data_t rx_data;
    logic            rx_done;
    logic            rx_done_q;
    uart_pkg::data_t tx_head;
    logic            tx_valid;
    logic            tx_pop;

    assign tx_valid = !o_tx_empty;

    baud_tick_gen u_baud_tick_gen (
        .o_tick     (tick),
        .i_tick_cmp (i_tick_cmp),
        .i_rst      (i_rst),
        .clk        (clk)
    );

    uart_rx u_uart_rx (
        .o_data    (rx_data),
        .o_rx_done (rx_done),
        .i_rx      (i_rx),
        .i_tick    (tick),
        .i_rst     (i_rst),
        .clk       (clk)
    );

    // Receive FIFO, written by the receiver, read by the host
    sync_fifo #(
        .NB_ADDR (`UART_NB_FIFO_ADDR)
    ) u_rx_fifo (
        .o_rdata (o_rdata),
        .o_empty (o_rx_empty),
        .o_full  (o_rx_full),
        .i_wr    (rx_done),
        .i_wdata (rx_data),
        .i_rd    (i_rd),
        .i_rst   (i_rst),
        .clk     (clk)
    );

    uart_tx u_uart_tx (
        .o_tx       (o_tx),
        .o_tx_done  (o_tx_done),
        .o_pop      (tx_pop),
        .i_data     (tx_head),
        .i_valid    (tx_valid),
        .i_tx_start (i_tx_start),
        .i_tick     (tick),
        .i_rst      (i_rst),
        .clk        (clk)
    );

    // Transmit FIFO, written by the host, popped on frame acceptance
    sync_fifo #(
        .NB_ADDR (`UART_NB_FIFO_ADDR)
    ) u_tx_fifo (
        .o_rdata (tx_head),
        .o_empty (o_tx_empty),
        .o_full  (o_tx_full),
        .i_wr    (i_wr),
        .i_wdata (i_wdata),
        .i_rd    (tx_pop),
        .i_rst   (i_rst),
        .clk     (clk)
    );

    // Delay by one so the pulse lines up with the FIFO write landing
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rx_done_q <= 1'b0;
        end else begin
            rx_done_q <= rx_done;
        end
    end

    assign o_rx_done = rx_done_q;

endmodule

// ==== hw/sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO
// Register array, read/write pointers and an occupancy count

`timescale 1ns/1ns
`include "uart_params.svh"

module sync_fifo #(
    parameter int NB_ADDR = `UART_NB_FIFO_ADDR    // Depth is 2**NB_ADDR
) (
    output uart_pkg::data_t o_rdata,              // Head entry, always visible
    output logic            o_empty,
    output logic            o_full,
    input  logic            i_wr,
    input  uart_pkg::data_t i_wdata,
    input  logic            i_rd,                 // Caller never reads when empty
    input  logic            i_rst,
    input  logic            clk
);

    localparam int DEPTH = 2 ** NB_ADDR;

    uart_pkg::data_t    mem [DEPTH];
    logic [NB_ADDR-1:0] wr_ptr;
    logic [NB_ADDR-1:0] rd_ptr;
    logic [NB_ADDR:0]   count;
    logic               wr_en;

    assign wr_en = i_wr && !o_full;   // Writes while full are dropped

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, i_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Push and pop cancel out
            endcase
        end
    end

    assign o_rdata = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == (NB_ADDR + 1)'(DEPTH));

endmodule

// ==== hw/uart_tx.sv ====
// UART transmitter
// Accepts a start strobe when idle and data is ready, pops the FIFO,
// then shifts start, 8 data bits LSB first and stop

`timescale 1ns/1ns
`include "uart_params.svh"

module uart_tx (
    output logic            o_tx,         // Serial line out
    output logic            o_tx_done,    // One-cycle pulse at end of stop bit
    output logic            o_pop,        // Pops the transmit FIFO head
    input  uart_pkg::data_t i_data,       // FIFO head
    input  logic            i_valid,      // FIFO not empty
    input  logic            i_tx_start,
    input  logic            i_tick,
    input  logic            i_rst,
    input  logic            clk
);

    localparam int NB_TICK = $clog2(`UART_OVERSAMPLE);
    localparam int NB_BIT  = $clog2(`UART_NB_DATA);

    localparam logic [NB_TICK-1:0] LAST_TICK = NB_TICK'(`UART_OVERSAMPLE - 1);
    localparam logic [NB_BIT-1:0]  LAST_BIT  = NB_BIT'(`UART_NB_DATA - 1);

    uart_pkg::frame_state_e state;
    logic [NB_TICK-1:0]     tick_cnt;
    logic [NB_BIT-1:0]      bit_cnt;
    logic                   tx_q;
    logic                   done_q;
    logic                   accept;
    logic                   bit_end;
    uart_pkg::data_t        shreg;

    // Busy or empty means the strobe is ignored
    assign accept  = (state == uart_pkg::IDLE) && i_tx_start && i_valid;
    assign bit_end = i_tick && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= uart_pkg::IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_q     <= 1'b1;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (i_tick && (state != uart_pkg::IDLE)) begin
                tick_cnt <= tick_cnt + 1'b1;     // Wraps every bit
            end
            case (state)
                uart_pkg::IDLE: begin
                    tx_q <= 1'b1;
                    if (accept) begin
                        state    <= uart_pkg::START;
                        tick_cnt <= '0;
                        tx_q     <= 1'b0;        // Start bit right away
                    end
                end
                uart_pkg::START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::DATA;
                        bit_cnt <= '0;
                        tx_q    <= shreg[0];
                    end
                end
                uart_pkg::DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= uart_pkg::STOP;
                            tx_q  <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_q    <= shreg[1];   // Next bit after the shift
                        end
                    end
                end
                uart_pkg::STOP: begin
                    if (bit_end) begin
                        state  <= uart_pkg::IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= uart_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= i_data;                     // Latch head before the pop lands
        end else if (bit_end && (state == uart_pkg::DATA)) begin
            shreg <= shreg >> 1;
        end
    end

    assign o_tx      = tx_q;
    assign o_tx_done = done_q;
    assign o_pop     = accept;

endmodule

// ==== hw/uart_rx.sv ====
// UART receiver, 16x oversampled
// Start bit confirmed at midpoint, data sampled LSB first,
// frame accepted only when the stop sample is high

`timescale 1ns/1ns
`include "uart_params.svh"

module uart_rx (
    output uart_pkg::data_t o_data,      // Last received byte
    output logic            o_rx_done,   // One-cycle pulse per good frame
    input  logic            i_rx,        // Serial line in
    input  logic            i_tick,      // Oversampling tick
    input  logic            i_rst,
    input  logic            clk
);

    localparam int NB_TICK = $clog2(`UART_OVERSAMPLE);
    localparam int NB_BIT  = $clog2(`UART_NB_DATA);

    localparam logic [NB_TICK-1:0] MID_TICK  = NB_TICK'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [NB_TICK-1:0] LAST_TICK = NB_TICK'(`UART_OVERSAMPLE - 1);
    localparam logic [NB_BIT-1:0]  LAST_BIT  = NB_BIT'(`UART_NB_DATA - 1);

    uart_pkg::frame_state_e state;
    logic [NB_TICK-1:0]     tick_cnt;
    logic [NB_BIT-1:0]      bit_cnt;
    logic [1:0]             rx_sync;    // Two-flop synchronizer on the line
    logic                   rx_s;
    logic                   done_q;
    uart_pkg::data_t        shreg;
    logic                   sample_data;

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rx_sync <= 2'b11;               // Idle line is high
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    // Midpoint of a data bit
    assign sample_data = i_tick && (state == uart_pkg::DATA) && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= uart_pkg::IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                uart_pkg::IDLE: begin
                    if (!rx_s) begin        // Possible start edge
                        state    <= uart_pkg::START;
                        tick_cnt <= '0;
                    end
                end
                uart_pkg::START: begin
                    if (i_tick) begin
                        if (tick_cnt == MID_TICK) begin
                            // Glitch shorter than half a bit goes back to idle
                            state    <= rx_s ? uart_pkg::IDLE : uart_pkg::DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;     // Wraps to zero at LAST_TICK
                        if (tick_cnt == LAST_TICK) begin
                            if (bit_cnt == LAST_BIT) begin
                                state <= uart_pkg::STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                uart_pkg::STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            state  <= uart_pkg::IDLE;
                            done_q <= rx_s;              // Low stop sample drops the frame
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= uart_pkg::IDLE;
            endcase
        end
    end

    // Shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if (sample_data) begin
            shreg <= {rx_s, shreg[`UART_NB_DATA-1:1]};
        end
    end

    assign o_data    = shreg;
    assign o_rx_done = done_q;

endmodule

// ==== hw/baud_tick_gen.sv ====
// Programmable baud tick generator
// One-cycle tick every i_tick_cmp+1 clocks

`timescale 1ns/1ns
`include "uart_params.svh"

module baud_tick_gen (
    output logic                          o_tick,       // Oversampling tick
    input  logic [`UART_NB_COUNTER-1:0]   i_tick_cmp,   // Wrap value of the counter
    input  logic                          i_rst,
    input  logic                          clk
);

    logic [`UART_NB_COUNTER-1:0] counter;
    logic                        tick_q;

    // Free-running counter, tick registered on the wrap
    always_ff @(posedge clk) begin
        if (i_rst) begin
            counter <= '0;
            tick_q  <= 1'b0;
        end else if (counter == i_tick_cmp) begin
            counter <= '0;
            tick_q  <= 1'b1;
        end else begin
            counter <= counter + 1'b1;
            tick_q  <= 1'b0;
        end
    end

    assign o_tick = tick_q;

endmodule

// ==== hw/uart_pkg.sv ====
// Shared UART types
// Data word and serial frame state

`include "uart_params.svh"

package uart_pkg;

    // One byte on the serial line
    typedef logic [`UART_NB_DATA-1:0] data_t;

    // Frame phases, common to receiver and transmitter
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // Line high, waiting
        START = 2'd1,   // Start bit
        DATA  = 2'd2,   // Data bits, LSB first
        STOP  = 2'd3    // Stop bit
    } frame_state_e;

endpackage

// ==== hw/uart_params.svh ====
// Widths and constants for the UART subsystem
// Data word, FIFO address, baud counter and oversampling rate

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Bits per serial data word
`define UART_NB_DATA 8

// FIFO address width, 32 entries
`define UART_NB_FIFO_ADDR 5

// Baud counter and tick compare width
`define UART_NB_COUNTER 9

// Ticks per serial bit
`define UART_OVERSAMPLE 16

`endif
